// ==== src/uart_pkg.sv ====
package uart_pkg;

    localparam int WORD_WIDTH = 32;

    // 115200 baud from a 50 MHz clock
    localparam int BAUD_DIV = 434;
    localparam int HALF_DIV = BAUD_DIV / 2;
    localparam int BAUD_W   = $clog2(BAUD_DIV);

    // 1 start, 8 data, 1 even parity, 1 stop
    localparam int DATA_BITS  = 8;
    localparam int FRAME_BITS = 11;
    localparam int BIT_W      = $clog2(FRAME_BITS);

    // haddr bit that splits tx and rx blocks
    localparam int SEL_BIT = 4;

    // only haddr[4:2] is decoded
    localparam logic [WORD_WIDTH-1:0] OFS_TXDATA = 32'h0000_0000;
    localparam logic [WORD_WIDTH-1:0] OFS_TXSTAT = 32'h0000_0004;
    localparam logic [WORD_WIDTH-1:0] OFS_RXDATA = 32'h0000_0010;
    localparam logic [WORD_WIDTH-1:0] OFS_RXSTAT = 32'h0000_0014;

    // ahb-lite transfer types that carry a transfer
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

endpackage

// ==== src/uart_tx.sv ====
module uart_tx import uart_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sel_tx,
    input  logic [WORD_WIDTH-1:0] haddr,
    input  logic [1:0]            htrans,
    input  logic                  hwrite,
    input  logic [WORD_WIDTH-1:0] hwdata,
    input  logic                  hready_in,
    input  logic                  tx_int_clear,
    output logic [WORD_WIDTH-1:0] hrdata,
    output logic                  hready,
    output logic                  hresp,
    output logic                  tx,
    output logic                  irq_tx
);

    logic                  dp_valid;
    logic                  dp_write;
    logic [2:0]            dp_addr;
    logic                  err_second;
    logic                  wr_txdata;
    logic                  busy_write;
    logic                  wr_start;
    logic                  busy;
    logic [FRAME_BITS-1:0] shift_reg;
    logic [BAUD_W-1:0]     baud_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic                  baud_tick;
    logic                  frame_done;

    // address phase, held while the bus is stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
        end else if (hready_in) begin
            dp_valid <= sel_tx && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);
        end
    end

    always_ff @(posedge clk) begin
        if (hready_in) begin
            dp_write <= hwrite;
            dp_addr  <= haddr[4:2];
        end
    end

    assign wr_txdata  = dp_valid && dp_write && (dp_addr == OFS_TXDATA[4:2]);
    assign busy_write = wr_txdata && busy && !err_second;
    // the second error cycle must not start a frame if busy just dropped
    assign wr_start   = wr_txdata && !busy && !err_second;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_second <= 1'b0;
        end else begin
            err_second <= busy_write;
        end
    end

    assign hready = !busy_write;
    assign hresp  = (busy_write || err_second) ? HRESP_ERROR : HRESP_OKAY;
    assign hrdata = (dp_valid && !dp_write && dp_addr == OFS_TXSTAT[4:2]) ?
                    {{(WORD_WIDTH-1){1'b0}}, busy} : '0;

    assign baud_tick  = busy && (baud_cnt == BAUD_W'(BAUD_DIV - 1));
    assign frame_done = baud_tick && (bit_cnt == BIT_W'(FRAME_BITS - 1));

    // serializer, line idles high through the ones shifted in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            shift_reg <= '1;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
        end else if (wr_start) begin
            busy      <= 1'b1;
            shift_reg <= {1'b1, ^hwdata[DATA_BITS-1:0], hwdata[DATA_BITS-1:0], 1'b0};
            baud_cnt  <= '0;
            bit_cnt   <= '0;
        end else if (busy) begin
            if (baud_tick) begin
                baud_cnt <= '0;
                if (frame_done) begin
                    busy <= 1'b0;
                end else begin
                    shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};
                    bit_cnt   <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    assign tx = shift_reg[0];

    // clear wins over a set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_tx <= 1'b0;
        end else if (tx_int_clear) begin
            irq_tx <= 1'b0;
        end else if (frame_done) begin
            irq_tx <= 1'b1;
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx);

    a_error_two_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (!hready && hresp == HRESP_ERROR) |=> (hready && hresp == HRESP_ERROR));

endmodule

// ==== src/uart_rx.sv ====
module uart_rx import uart_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sel_rx,
    input  logic [WORD_WIDTH-1:0] haddr,
    input  logic [1:0]            htrans,
    input  logic                  hwrite,
    input  logic                  hready_in,
    input  logic                  rx,
    input  logic                  rx_int_clear,
    output logic [WORD_WIDTH-1:0] hrdata,
    output logic                  irq_rx
);

    logic                 dp_valid;
    logic                 dp_write;
    logic [2:0]           dp_addr;
    logic                 rd_rxdata;
    logic                 rd_rxstat;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;
    logic                 start_edge;
    logic                 active;
    logic [BAUD_W-1:0]    baud_cnt;
    logic [BIT_W-1:0]     bit_cnt;
    logic                 sample;
    logic                 stop_sample;
    logic [DATA_BITS-1:0] shift_reg;
    logic                 par_bit;
    logic [DATA_BITS-1:0] rx_data;
    logic                 valid;
    logic                 par_err;
    logic                 overrun;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
        end else if (hready_in) begin
            dp_valid <= sel_rx && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);
        end
    end

    always_ff @(posedge clk) begin
        if (hready_in) begin
            dp_write <= hwrite;
            dp_addr  <= haddr[4:2];
        end
    end

    assign rd_rxdata = dp_valid && !dp_write && (dp_addr == OFS_RXDATA[4:2]);
    assign rd_rxstat = dp_valid && !dp_write && (dp_addr == OFS_RXSTAT[4:2]);

    assign hrdata = rd_rxdata ? {{(WORD_WIDTH-DATA_BITS){1'b0}}, rx_data} :
                    rd_rxstat ? {{(WORD_WIDTH-3){1'b0}}, overrun, par_err, valid} : '0;

    // two-flop synchronizer plus one more for the edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge  = !active && rx_prev && !rx_sync;
    // start bit checked at half a bit, the rest one bit apart
    assign sample      = active && ((bit_cnt == '0) ? (baud_cnt == BAUD_W'(HALF_DIV - 1)) :
                                                      (baud_cnt == BAUD_W'(BAUD_DIV - 1)));
    assign stop_sample = sample && (bit_cnt == BIT_W'(FRAME_BITS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (start_edge) begin
            active   <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (active) begin
            if (sample) begin
                baud_cnt <= '0;
                // glitch, not a start bit
                if (bit_cnt == '0 && rx_sync) begin
                    active <= 1'b0;
                end else if (stop_sample) begin
                    active <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // data arrives lsb first
    always_ff @(posedge clk) begin
        if (sample && bit_cnt >= BIT_W'(1) && bit_cnt <= BIT_W'(DATA_BITS)) begin
            shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
        end
        if (sample && bit_cnt == BIT_W'(DATA_BITS + 1)) begin
            par_bit <= rx_sync;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_data <= '0;
            valid   <= 1'b0;
            par_err <= 1'b0;
            overrun <= 1'b0;
        end else if (stop_sample) begin
            rx_data <= shift_reg;
            valid   <= 1'b1;
            par_err <= ^{shift_reg, par_bit};
            // old byte lost unless read in this same cycle
            overrun <= valid && !rd_rxdata;
        end else if (rd_rxdata) begin
            valid   <= 1'b0;
            overrun <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_rx <= 1'b0;
        end else if (rx_int_clear) begin
            irq_rx <= 1'b0;
        end else if (stop_sample) begin
            irq_rx <= 1'b1;
        end
    end

    a_overrun_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        overrun |-> valid);

endmodule

// ==== src/uart.sv ====
module uart import uart_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  hsel,
    input  logic [WORD_WIDTH-1:0] haddr,
    input  logic [1:0]            htrans,
    input  logic                  hwrite,
    // every access is a full word
    input  logic [2:0]            hsize,
    input  logic [WORD_WIDTH-1:0] hwdata,
    input  logic                  rx,
    input  logic                  tx_int_clear,
    input  logic                  rx_int_clear,
    output logic [WORD_WIDTH-1:0] hrdata,
    output logic                  hready,
    output logic                  hresp,
    output logic                  tx,
    output logic                  irq_tx,
    output logic                  irq_rx
);

    logic                  sel_tx;
    logic                  sel_rx;
    logic                  trans_act;
    logic                  own_tx;
    logic                  own_rx;
    logic [WORD_WIDTH-1:0] tx_hrdata;
    logic                  tx_hready;
    logic                  tx_hresp;
    logic [WORD_WIDTH-1:0] rx_hrdata;

    assign sel_tx    = hsel && !haddr[SEL_BIT];
    assign sel_rx    = hsel && haddr[SEL_BIT];
    assign trans_act = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);

    // owner of the next data phase, held through a stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            own_tx <= 1'b0;
            own_rx <= 1'b0;
        end else if (hready) begin
            own_tx <= sel_tx && trans_act;
            own_rx <= sel_rx && trans_act;
        end
    end

    uart_tx u_uart_tx (
        .clk          (clk),
        .rst_n        (rst_n),
        .sel_tx       (sel_tx),
        .haddr        (haddr),
        .htrans       (htrans),
        .hwrite       (hwrite),
        .hwdata       (hwdata),
        .hready_in    (hready),
        .tx_int_clear (tx_int_clear),
        .hrdata       (tx_hrdata),
        .hready       (tx_hready),
        .hresp        (tx_hresp),
        .tx           (tx),
        .irq_tx       (irq_tx)
    );

    uart_rx u_uart_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .sel_rx       (sel_rx),
        .haddr        (haddr),
        .htrans       (htrans),
        .hwrite       (hwrite),
        .hready_in    (hready),
        .rx           (rx),
        .rx_int_clear (rx_int_clear),
        .hrdata       (rx_hrdata),
        .irq_rx       (irq_rx)
    );

    // receiver never stalls and never errors
    assign hrdata = own_tx ? tx_hrdata : own_rx ? rx_hrdata : '0;
    assign hready = own_tx ? tx_hready : 1'b1;
    assign hresp  = own_tx ? tx_hresp  : HRESP_OKAY;

endmodule

// ==== tb/tb_uart.sv ====
module tb_uart import uart_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst_n;
    logic        hsel;
    logic [31:0] haddr;
    logic [1:0]  htrans;
    logic        hwrite;
    logic [2:0]  hsize;
    logic [31:0] hwdata;
    logic        rx;
    logic        tx_int_clear;
    logic        rx_int_clear;
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;
    logic        tx;
    logic        irq_tx;
    logic        irq_rx;

    logic [7:0]  tx_frames[$];
    logic [9:0]  mon_bits;
    logic        mon_busy;
    int          fd;
    string       cmd;

    uart uart_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .hsel         (hsel),
        .haddr        (haddr),
        .htrans       (htrans),
        .hwrite       (hwrite),
        .hsize        (hsize),
        .hwdata       (hwdata),
        .rx           (rx),
        .tx_int_clear (tx_int_clear),
        .rx_int_clear (rx_int_clear),
        .hrdata       (hrdata),
        .hready       (hready),
        .hresp        (hresp),
        .tx           (tx),
        .irq_tx       (irq_tx),
        .irq_rx       (irq_rx)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] seen);
        assert (seen === expected) else fail_run($sformatf(
            "MISMATCH time=%0t signal=%s expected=0x%0h seen=0x%0h",
            $time, name, expected, seen));
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!hready && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        assert (hready) else fail_run("bus did not return hready within 16 cycles");
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input bit want_error);
        @(negedge clk);
        hsel   = 1'b1;
        haddr  = addr;
        htrans = HTRANS_NONSEQ;
        hwrite = 1'b1;
        @(negedge clk);
        hsel   = 1'b0;
        htrans = 2'b00;
        hwrite = 1'b0;
        hwdata = data;
        if (want_error) begin
            // two-cycle error response
            check_value("hready", 0, 32'(hready));
            check_value("hresp", 32'(HRESP_ERROR), 32'(hresp));
            @(negedge clk);
            check_value("hready", 1, 32'(hready));
            check_value("hresp", 32'(HRESP_ERROR), 32'(hresp));
        end else begin
            wait_ready();
            check_value("hresp", 32'(HRESP_OKAY), 32'(hresp));
        end
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [31:0] expected);
        @(negedge clk);
        hsel   = 1'b1;
        haddr  = addr;
        htrans = HTRANS_NONSEQ;
        hwrite = 1'b0;
        @(negedge clk);
        hsel   = 1'b0;
        htrans = 2'b00;
        wait_ready();
        check_value("hresp", 32'(HRESP_OKAY), 32'(hresp));
        check_value("hrdata", expected, hrdata);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (^data) ^ bad_parity, data, 1'b0};
        @(negedge clk);
        for (int i = 0; i < FRAME_BITS; i++) begin
            rx = frame[i];
            repeat (BAUD_DIV) @(negedge clk);
        end
    endtask

    task automatic expect_frame(input logic [7:0] data);
        int         waited;
        logic [7:0] got;
        waited = 0;
        while (tx_frames.size() == 0 && waited < 2 * FRAME_BITS * BAUD_DIV) begin
            @(negedge clk);
            waited++;
        end
        assert (tx_frames.size() != 0) else fail_run("no frame appeared on tx in time");
        got = tx_frames.pop_front();
        check_value("tx data", 32'(data), 32'(got));
    endtask

    task automatic pulse_clears(input logic clr_tx, input logic clr_rx);
        @(negedge clk);
        tx_int_clear = clr_tx;
        rx_int_clear = clr_rx;
        @(negedge clk);
        tx_int_clear = 1'b0;
        rx_int_clear = 1'b0;
    endtask

    task automatic run_command(input string op);
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        int          n;
        string       rest;
        arg_a = '0;
        arg_b = '0;
        if (op.substr(0, 0) == "#") begin
            n = $fgets(rest, fd);
        end else if (op == "T") begin
            n = $fscanf(fd, " %h", arg_a);
            assert (n == 1) else fail_run("stim file: T needs one argument");
            expect_frame(arg_a[7:0]);
        end else begin
            n = $fscanf(fd, " %h %h", arg_a, arg_b);
            assert (n == 2) else fail_run($sformatf("stim file: %s needs two arguments", op));
            if (op == "W") begin
                bus_write(arg_a, arg_b, 1'b0);
            end else if (op == "E") begin
                bus_write(arg_a, arg_b, 1'b1);
            end else if (op == "R") begin
                bus_read(arg_a, arg_b);
            end else if (op == "S") begin
                send_frame(arg_a[7:0], arg_b[0]);
            end else if (op == "I") begin
                check_value("irq_tx", 32'(arg_a[0]), 32'(irq_tx));
                check_value("irq_rx", 32'(arg_b[0]), 32'(irq_rx));
            end else if (op == "C") begin
                pulse_clears(arg_a[0], arg_b[0]);
            end else begin
                fail_run($sformatf("stim file holds an unknown command %s", op));
            end
        end
    endtask

    // decodes each frame on tx at the middle of its bits
    always begin
        @(negedge clk);
        if (rst_n && !tx) begin
            mon_busy = 1'b1;
            repeat (HALF_DIV) @(negedge clk);
            check_value("tx start bit", 0, 32'(tx));
            for (int i = 0; i < FRAME_BITS - 1; i++) begin
                repeat (BAUD_DIV) @(negedge clk);
                mon_bits[i] = tx;
            end
            check_value("tx parity bit", 32'(^mon_bits[7:0]), 32'(mon_bits[8]));
            check_value("tx stop bit", 1, 32'(mon_bits[9]));
            // report only once the stop bit is over
            repeat (HALF_DIV + 1) @(negedge clk);
            tx_frames.push_back(mon_bits[7:0]);
            mon_busy = 1'b0;
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        hsel         = 1'b0;
        haddr        = '0;
        htrans       = 2'b00;
        hwrite       = 1'b0;
        hsize        = 3'b010;
        hwdata       = '0;
        rx           = 1'b1;
        tx_int_clear = 1'b0;
        rx_int_clear = 1'b0;
        mon_busy     = 1'b0;
        mon_bits     = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("tx", 1, 32'(tx));

        fd = $fopen("tb/uart_stim.txt", "r");
        assert (fd != 0) else fail_run("could not open tb/uart_stim.txt");
        while ($fscanf(fd, " %s", cmd) == 1) begin
            run_command(cmd);
        end
        $fclose(fd);

        // no extra frame may follow the refused write
        check_value("tx frames left", 0, 32'(tx_frames.size()));
        check_value("tx monitor busy", 0, 32'(mon_busy));
        bus_read(OFS_TXSTAT, 0);
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== tb/uart_stim.txt ====
# cmd arg1 arg2, all values hex
# W/R/E addr data, S byte badpar, T byte, I/C irq_tx irq_rx
# after reset
I 0 0
R 4 0
R 14 0
# one byte out, a write while busy is refused
W 0 A5
R 4 1
I 0 0
E 0 3C
R 4 1
T A5
R 4 0
I 1 0
C 1 0
I 0 0
# good frame in
S 5A 0
I 0 1
R 14 1
R 10 5A
R 14 0
C 0 1
I 0 0
# bad parity, then overrun
S 33 1
R 14 3
R 10 33
R 14 2
S 11 0
S 22 0
R 14 5
R 10 22
R 14 0
C 0 1
# unmapped offsets
R 0 0
R 8 0
R C 0
R 18 0
R 1C 0

// ==== vlog.f ====
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart.sv
tb/tb_uart.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_uart
RTL_TOP    ?= uart
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP) tb/uart_stim.txt
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
